// File: verilog/epd_timing_pkg.sv
/*
 * Frame scan definitions for the EPD controller.
 * Holds the scan state encoding, the timing region flags and the fixed
 * timing constants shared by the scan modules and the top level.
 */
`default_nettype none

package epd_timing_pkg;

    // Frame sequencer states
    typedef enum logic [1:0] {
        SCAN_IDLE    = 2'd0,
        SCAN_WAITING = 2'd1,
        SCAN_RUNNING = 2'd2
    } scan_state_e;

    // Decoded position of the scan counters
    typedef struct packed {
        logic in_vsync;
        logic in_vbp;
        logic in_vact;
        logic in_hfp;
        logic in_hsync;
        logic in_hact;
        logic fetch;
        logic line_start;
    } scan_region_t;

    // Clocks spent waiting after vsync
    localparam int VS_DELAY = 8;
    // Fetch window leads the active window by this much
    localparam int PIPE_DELAY = 4;
    localparam int CNT_W = 11;

endpackage

`default_nettype wire

// File: verilog/wvfm_pkg.sv
/*
 * Waveform path definitions for the EPD controller.
 * Pixel state word, LUT address and LUT write port types, used by the
 * pixel pipeline, the waveform RAM, the top level and the testbench.
 */
`default_nettype none

package wvfm_pkg;

    localparam int PIX_PER_CLK = 4;
    localparam int GRAY_W = 4;
    localparam int FCNT_W = 6;
    localparam int DRIVE_W = 2;
    localparam int LUT_ADDR_W = 14;

    // Framebuffer state of one pixel, 16 bits
    typedef struct packed {
        logic [1:0]        rsvd;
        logic [FCNT_W-1:0] fcnt;  // frames left in the transition
        logic [GRAY_W-1:0] src;
        logic [GRAY_W-1:0] tgt;
    } pix_state_t;

    typedef struct packed {
        logic [FCNT_W-1:0] seq;
        logic [GRAY_W-1:0] src;
        logic [GRAY_W-1:0] tgt;
    } lut_addr_t;

    typedef struct packed {
        logic               we;
        lut_addr_t          addr;
        logic [DRIVE_W-1:0] data;
    } lut_wr_t;

endpackage

`default_nettype wire

// File: verilog/scan_fsm.sv
/*
 * Frame level sequencer of the EPD scan.
 * Waits for vsync, holds b_trigger during a short waiting phase, then runs
 * one frame. frame_valid masks the frame output after a FIFO underrun.
 */
`timescale 1ns/1ps
`default_nettype none

module scan_fsm (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 vin_vsync,
    input  wire logic                 sys_ready,
    input  wire logic                 global_en,
    input  wire logic                 line_end,
    input  wire logic                 frame_end,
    input  wire logic                 underrun,
    output epd_timing_pkg::scan_state_e state,
    output logic                      frame_valid,
    output logic                      b_trigger
);

    localparam int WAIT_W = $clog2(epd_timing_pkg::VS_DELAY + 1);

    logic [WAIT_W-1:0] wait_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= epd_timing_pkg::SCAN_IDLE;
            wait_cnt    <= '0;
            frame_valid <= 1'b0;
        end else begin
            case (state)
                epd_timing_pkg::SCAN_IDLE: begin
                    wait_cnt <= '0;
                    if (vin_vsync && sys_ready && global_en) begin
                        state <= epd_timing_pkg::SCAN_WAITING;
                    end
                end
                epd_timing_pkg::SCAN_WAITING: begin
                    if (wait_cnt == WAIT_W'(epd_timing_pkg::VS_DELAY)) begin
                        state       <= epd_timing_pkg::SCAN_RUNNING;
                        frame_valid <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                epd_timing_pkg::SCAN_RUNNING: begin
                    // Last clock of the last line
                    if (line_end && frame_end) begin
                        state <= epd_timing_pkg::SCAN_IDLE;
                    end
                end
                default: state <= epd_timing_pkg::SCAN_IDLE;
            endcase
            // Kill stays until the next waiting phase
            if (underrun) begin
                frame_valid <= 1'b0;
            end
        end
    end

    assign b_trigger = state == epd_timing_pkg::SCAN_WAITING;

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {epd_timing_pkg::SCAN_IDLE, epd_timing_pkg::SCAN_WAITING,
                      epd_timing_pkg::SCAN_RUNNING});

endmodule

`default_nettype wire

// File: verilog/scan_timing.sv
/*
 * Horizontal and vertical scan counters of the EPD controller.
 * Decodes the timing regions, opens the fetch window PIPE_DELAY clocks
 * ahead of the active pixels and drives the gate and source driver pins.
 */
`timescale 1ns/1ps
`default_nettype none

module scan_timing #(
    parameter int H_FP   = 2,
    parameter int H_SYNC = 2,
    parameter int H_BP   = 2,
    parameter int H_ACT  = 8,
    parameter int V_FP   = 1,
    parameter int V_SYNC = 1,
    parameter int V_BP   = 1,
    parameter int V_ACT  = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire epd_timing_pkg::scan_state_e state,
    output epd_timing_pkg::scan_region_t    region,
    output logic                            line_end,
    output logic                            frame_end,
    output logic                            epd_gdoe,
    output logic                            epd_gdclk,
    output logic                            epd_gdsp,
    output logic                            epd_sdclk,
    output logic                            epd_sdle,
    output logic                            epd_sdoe,
    output logic                            epd_sdce0
);

    localparam int CW = epd_timing_pkg::CNT_W;
    localparam int HTOTAL = H_FP + H_SYNC + H_BP + H_ACT;
    localparam int VTOTAL = V_FP + V_SYNC + V_BP + V_ACT;
    localparam int H_ACT_START = H_FP + H_SYNC + H_BP;
    localparam int V_ACT_START = V_FP + V_SYNC + V_BP;
    localparam int FETCH_START = H_ACT_START - epd_timing_pkg::PIPE_DELAY;
    localparam int FETCH_END = HTOTAL - epd_timing_pkg::PIPE_DELAY;

    logic [CW-1:0] h_cnt;
    logic [CW-1:0] v_cnt;
    logic          running;
    logic          gdclk_pre;

    assign running   = state == epd_timing_pkg::SCAN_RUNNING;
    assign line_end  = running && (h_cnt == CW'(HTOTAL - 1));
    assign frame_end = running && (v_cnt == CW'(VTOTAL - 1));

    // Counters sit at zero outside the running state
    always_ff @(posedge clk) begin
        if (rst || !running) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;
            v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_comb begin
        region.in_vsync = running && (v_cnt >= CW'(V_FP)) && (v_cnt < CW'(V_FP + V_SYNC));
        region.in_vbp = running && (v_cnt >= CW'(V_FP + V_SYNC)) &&
                        (v_cnt < CW'(V_ACT_START));
        region.in_vact = running && (v_cnt >= CW'(V_ACT_START));
        region.in_hfp = running && (h_cnt < CW'(H_FP));
        region.in_hsync = running && (h_cnt >= CW'(H_FP)) && (h_cnt < CW'(H_FP + H_SYNC));
        region.in_hact = running && (h_cnt >= CW'(H_ACT_START));
        // Same length as the active window, shifted earlier
        region.fetch = region.in_vact && (h_cnt >= CW'(FETCH_START)) &&
                       (h_cnt < CW'(FETCH_END));
        region.line_start = running && (h_cnt == '0);
    end

    // Gate driver
    assign gdclk_pre = running && !region.in_hfp;

    always_ff @(posedge clk) begin
        if (rst) begin
            epd_gdclk <= 1'b0;
        end else begin
            epd_gdclk <= gdclk_pre;
        end
    end

    assign epd_gdoe = region.in_vsync || region.in_vbp || region.in_vact;
    assign epd_gdsp = !region.in_vsync;

    // Source driver
    assign epd_sdoe  = epd_gdoe;
    assign epd_sdle  = region.in_hsync;
    assign epd_sdce0 = !(region.in_vact && region.in_hact);
    assign epd_sdclk = (region.in_hfp || region.in_hsync || region.in_hact) ? ~clk : 1'b0;

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        (h_cnt < CW'(HTOTAL)) && (v_cnt < CW'(VTOTAL)));

endmodule

`default_nettype wire

// File: verilog/wvfm_lut.sv
/*
 * Waveform RAM, 16K entries of one drive code each.
 * One write port for loading and four registered read ports, one for
 * each pixel of a clock. Read data appears one clock after the address.
 */
`timescale 1ns/1ps
`default_nettype none

module wvfm_lut (
    input  wire logic                                              clk,
    input  wire wvfm_pkg::lut_wr_t                                 wr,
    input  wire wvfm_pkg::lut_addr_t [wvfm_pkg::PIX_PER_CLK-1:0]  rd_addr,
    output logic [wvfm_pkg::PIX_PER_CLK-1:0][wvfm_pkg::DRIVE_W-1:0] rd_data
);

    logic [wvfm_pkg::DRIVE_W-1:0] mem [2**wvfm_pkg::LUT_ADDR_W];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
        for (int i = 0; i < wvfm_pkg::PIX_PER_CLK; i++) begin
            rd_data[i] <= mem[rd_addr[i]];
        end
    end

    a_wr_addr_known: assert property (@(posedge clk)
        wr.we |-> !$isunknown(wr.addr));

endmodule

`default_nettype wire

// File: verilog/pixel_pipeline.sv
/*
 * Four stage pixel pipeline, four pixels per clock.
 * Takes image and state data one clock after fetch, looks up the waveform,
 * applies the transition rule and registers drive codes and writeback.
 * Results leave exactly four clocks after the matching fetch cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_pipeline #(
    parameter int LUT_FRAMES = 3
) (
    input  wire logic                                               clk,
    input  wire logic                                               rst,
    input  wire logic                                               fetch,
    input  wire logic                                               frame_valid,
    input  wire logic [wvfm_pkg::PIX_PER_CLK-1:0][7:0]              vin_pixel,
    input  wire logic                                               vin_valid,
    input  wire wvfm_pkg::pix_state_t [wvfm_pkg::PIX_PER_CLK-1:0]   bi_pixel,
    input  wire logic                                               bi_valid,
    input  wire wvfm_pkg::lut_wr_t                                  lut_wr,
    output logic                                                    underrun,
    output wvfm_pkg::pix_state_t [wvfm_pkg::PIX_PER_CLK-1:0]        bo_pixel,
    output logic                                                    bo_valid,
    output logic [wvfm_pkg::PIX_PER_CLK-1:0][wvfm_pkg::DRIVE_W-1:0] epd_sd
);

    localparam int N  = wvfm_pkg::PIX_PER_CLK;
    localparam int GW = wvfm_pkg::GRAY_W;
    localparam int FW = wvfm_pkg::FCNT_W;
    localparam logic [FW-1:0] LF = FW'(LUT_FRAMES);
    localparam logic [FW-1:0] LF_M1 = FW'(LUT_FRAMES - 1);

    logic                                  d_vld;
    logic                                  s1_vld;
    logic                                  s2_vld;
    wvfm_pkg::lut_addr_t  [N-1:0]          addr;
    wvfm_pkg::lut_addr_t  [N-1:0]          s1_addr;
    logic [N-1:0][GW-1:0]                  s1_gray;
    logic [N-1:0][GW-1:0]                  s2_gray;
    wvfm_pkg::pix_state_t [N-1:0]          s1_state;
    wvfm_pkg::pix_state_t [N-1:0]          s2_state;
    wvfm_pkg::pix_state_t [N-1:0]          nxt_state;
    logic [N-1:0][wvfm_pkg::DRIVE_W-1:0]   lut_rd;
    logic [N-1:0][wvfm_pkg::DRIVE_W-1:0]   drive;

    // Both FIFOs dry in a data cycle
    assign underrun = d_vld && !vin_valid && !bi_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            d_vld    <= 1'b0;
            s1_vld   <= 1'b0;
            s2_vld   <= 1'b0;
            bo_valid <= 1'b0;
            epd_sd   <= '0;
        end else begin
            d_vld    <= fetch;
            s1_vld   <= d_vld;
            s2_vld   <= s1_vld;
            bo_valid <= s2_vld;
            epd_sd   <= s2_vld ? drive : '0;
        end
    end

    // Stage 1 address, idle pixels look at seq 0 toward the new gray
    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (bi_pixel[i].fcnt == '0) begin
                addr[i] = '{seq: '0, src: bi_pixel[i].src, tgt: vin_pixel[i][7:4]};
            end else begin
                addr[i] = '{seq: LF - bi_pixel[i].fcnt, src: bi_pixel[i].src,
                            tgt: bi_pixel[i].tgt};
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            s1_gray[i] <= vin_pixel[i][7:4];
        end
        s1_addr  <= addr;
        s1_state <= bi_pixel;
        // Stage 2 holds the pixel while the LUT reads
        s2_gray  <= s1_gray;
        s2_state <= s1_state;
    end

    wvfm_lut u_lut (
        .clk     (clk),
        .wr      (lut_wr),
        .rd_addr (s1_addr),
        .rd_data (lut_rd)
    );

    // Stage 3 transition rule
    always_comb begin
        for (int i = 0; i < N; i++) begin
            nxt_state[i] = s2_state[i];
            drive[i]     = lut_rd[i];
            if (s2_state[i].fcnt == '0) begin
                if (s2_gray[i] == s2_state[i].src) begin
                    drive[i] = '0;
                end else begin
                    nxt_state[i].tgt  = s2_gray[i];
                    nxt_state[i].fcnt = LF_M1;
                    // Single frame waveform finishes at once
                    if (LF_M1 == '0) begin
                        nxt_state[i].src = s2_gray[i];
                    end
                end
            end else begin
                nxt_state[i].fcnt = s2_state[i].fcnt - 1'b1;
                if (s2_state[i].fcnt == FW'(1)) begin
                    nxt_state[i].src = s2_state[i].tgt;
                end
            end
            if (!frame_valid) begin
                drive[i]     = '0;
                nxt_state[i] = s2_state[i];
            end
        end
    end

    // Stage 4 writeback
    always_ff @(posedge clk) begin
        bo_pixel <= nxt_state;
    end

    a_bo_after_fetch: assert property (@(posedge clk) disable iff (rst)
        bo_valid |-> $past(fetch, 4));

endmodule

`default_nettype wire

// File: verilog/epd_caster.sv
/*
 * EPD controller top level.
 * Sets the panel timing and waveform length and connects the frame
 * sequencer, the scan timing and the pixel pipeline. Input data lags
 * ready by one clock, as from a standard FIFO.
 */
`timescale 1ns/1ps
`default_nettype none

module epd_caster #(
    parameter int H_FP       = 2,
    parameter int H_SYNC     = 2,
    parameter int H_BP       = 2,
    parameter int H_ACT      = 8,
    parameter int V_FP       = 1,
    parameter int V_SYNC     = 1,
    parameter int V_BP       = 1,
    parameter int V_ACT      = 4,
    parameter int LUT_FRAMES = 3
) (
    input  wire logic                                               clk,
    input  wire logic                                               rst,
    input  wire logic                                               vin_vsync,
    input  wire logic [wvfm_pkg::PIX_PER_CLK-1:0][7:0]              vin_pixel,
    input  wire logic                                               vin_valid,
    output logic                                                    vin_ready,
    input  wire wvfm_pkg::pix_state_t [wvfm_pkg::PIX_PER_CLK-1:0]   bi_pixel,
    input  wire logic                                               bi_valid,
    output logic                                                    bi_ready,
    output wvfm_pkg::pix_state_t [wvfm_pkg::PIX_PER_CLK-1:0]        bo_pixel,
    output logic                                                    bo_valid,
    input  wire wvfm_pkg::lut_wr_t                                  lut_wr,
    input  wire logic                                               sys_ready,
    input  wire logic                                               global_en,
    output logic                                                    b_trigger,
    output logic                                                    epd_gdoe,
    output logic                                                    epd_gdclk,
    output logic                                                    epd_gdsp,
    output logic                                                    epd_sdclk,
    output logic                                                    epd_sdle,
    output logic                                                    epd_sdoe,
    output logic                                                    epd_sdce0,
    output logic [wvfm_pkg::PIX_PER_CLK-1:0][wvfm_pkg::DRIVE_W-1:0] epd_sd
);

    epd_timing_pkg::scan_state_e  state;
    epd_timing_pkg::scan_region_t region;
    logic                         frame_valid;
    logic                         underrun;
    logic                         line_end;
    logic                         frame_end;

    // Both FIFOs are read in the fetch window
    assign vin_ready = region.fetch;
    assign bi_ready  = region.fetch;

    scan_fsm u_fsm (
        .clk         (clk),
        .rst         (rst),
        .vin_vsync   (vin_vsync),
        .sys_ready   (sys_ready),
        .global_en   (global_en),
        .line_end    (line_end),
        .frame_end   (frame_end),
        .underrun    (underrun),
        .state       (state),
        .frame_valid (frame_valid),
        .b_trigger   (b_trigger)
    );

    scan_timing #(
        .H_FP   (H_FP),
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .H_ACT  (H_ACT),
        .V_FP   (V_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .V_ACT  (V_ACT)
    ) u_timing (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .region    (region),
        .line_end  (line_end),
        .frame_end (frame_end),
        .epd_gdoe  (epd_gdoe),
        .epd_gdclk (epd_gdclk),
        .epd_gdsp  (epd_gdsp),
        .epd_sdclk (epd_sdclk),
        .epd_sdle  (epd_sdle),
        .epd_sdoe  (epd_sdoe),
        .epd_sdce0 (epd_sdce0)
    );

    pixel_pipeline #(
        .LUT_FRAMES (LUT_FRAMES)
    ) u_pipe (
        .clk         (clk),
        .rst         (rst),
        .fetch       (region.fetch),
        .frame_valid (frame_valid),
        .vin_pixel   (vin_pixel),
        .vin_valid   (vin_valid),
        .bi_pixel    (bi_pixel),
        .bi_valid    (bi_valid),
        .lut_wr      (lut_wr),
        .underrun    (underrun),
        .bo_pixel    (bo_pixel),
        .bo_valid    (bo_valid),
        .epd_sd      (epd_sd)
    );

endmodule

`default_nettype wire

// File: include/tb_ref_model.svh
/*
 * Reference model of the per-pixel transition rule and a shadow copy of
 * the waveform LUT. Included inside the testbench module, which writes
 * lut_shadow along with every LUT load and calls ref_beat per result.
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

logic [wvfm_pkg::DRIVE_W-1:0] lut_shadow [2**wvfm_pkg::LUT_ADDR_W];

function automatic void ref_pixel(
    input  wvfm_pkg::pix_state_t          st,
    input  logic [wvfm_pkg::GRAY_W-1:0]   g,
    input  logic [wvfm_pkg::FCNT_W-1:0]   lut_frames,
    output logic [wvfm_pkg::DRIVE_W-1:0]  drive,
    output wvfm_pkg::pix_state_t          nxt
);
    wvfm_pkg::lut_addr_t a;
    nxt = st;
    if (st.fcnt == 0 && g == st.src) begin
        drive = '0;
    end else if (st.fcnt == 0) begin
        a = '{seq: '0, src: st.src, tgt: g};
        drive = lut_shadow[a];
        nxt.tgt = g;
        nxt.fcnt = lut_frames - 1'b1;
        if (lut_frames == 1) begin
            nxt.src = g;
        end
    end else begin
        // Mid transition, input gray is ignored
        a = '{seq: lut_frames - st.fcnt, src: st.src, tgt: st.tgt};
        drive = lut_shadow[a];
        nxt.fcnt = st.fcnt - 1'b1;
        if (st.fcnt == 1) begin
            nxt.src = st.tgt;
        end
    end
endfunction

// One clock of four pixels, killed frames pass the state through
function automatic void ref_beat(
    input  logic [wvfm_pkg::PIX_PER_CLK-1:0][7:0]                    vin,
    input  wvfm_pkg::pix_state_t [wvfm_pkg::PIX_PER_CLK-1:0]         bi,
    input  logic [wvfm_pkg::FCNT_W-1:0]                              lut_frames,
    input  logic                                                     kill,
    output logic [wvfm_pkg::PIX_PER_CLK-1:0][wvfm_pkg::DRIVE_W-1:0]  sd,
    output wvfm_pkg::pix_state_t [wvfm_pkg::PIX_PER_CLK-1:0]         bo
);
    for (int i = 0; i < wvfm_pkg::PIX_PER_CLK; i++) begin
        ref_pixel(bi[i], vin[i][7:4], lut_frames, sd[i], bo[i]);
        if (kill) begin
            sd[i] = '0;
            bo[i] = bi[i];
        end
    end
endfunction

`endif

// File: sim/tb_epd_caster.sv
/*
 * Testbench for the EPD controller top level.
 * Loads the waveform LUT, runs six short frames against a FIFO model that
 * answers each ready one clock later, and compares every result with the
 * reference model. Results print per test, then a closing summary.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_epd_caster;

    localparam int H_FP = 2;
    localparam int H_SYNC = 2;
    localparam int H_BP = 2;
    localparam int H_ACT = 8;
    localparam int V_FP = 1;
    localparam int V_SYNC = 1;
    localparam int V_BP = 1;
    localparam int V_ACT = 4;
    localparam int LUT_FRAMES = 3;

    localparam int N = wvfm_pkg::PIX_PER_CLK;
    localparam int FW = wvfm_pkg::FCNT_W;
    localparam int HTOTAL = H_FP + H_SYNC + H_BP + H_ACT;
    localparam int VTOTAL = V_FP + V_SYNC + V_BP + V_ACT;
    localparam int ITEMS = V_ACT * H_ACT;
    // Only seq 0 to LUT_FRAMES-1 is ever read
    localparam int LOAD_N = LUT_FRAMES * (2 ** (2 * wvfm_pkg::GRAY_W));
    // Starved item opens the third active line so no earlier item is in flight
    localparam int STARVE_IDX = 2 * H_ACT;
    localparam int NUM_FRAMES = 6;
    localparam int FRAME_CYC = HTOTAL * VTOTAL + epd_timing_pkg::VS_DELAY + 1 + 8;
    localparam int CYCLE_LIMIT = 5 + LOAD_N + NUM_FRAMES * FRAME_CYC + 200;

    localparam int MODE_STEADY = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_FEEDBACK = 2;
    localparam int MODE_STARVE = 3;

    typedef struct packed {
        logic [N-1:0][wvfm_pkg::DRIVE_W-1:0] sd;
        wvfm_pkg::pix_state_t [N-1:0]        bo;
    } result_t;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                vin_vsync;
    logic [N-1:0][7:0]                   vin_pixel;
    logic                                vin_valid;
    logic                                vin_ready;
    wvfm_pkg::pix_state_t [N-1:0]        bi_pixel;
    logic                                bi_valid;
    logic                                bi_ready;
    wvfm_pkg::pix_state_t [N-1:0]        bo_pixel;
    logic                                bo_valid;
    wvfm_pkg::lut_wr_t                   lut_wr;
    logic                                sys_ready;
    logic                                global_en;
    logic                                b_trigger;
    logic                                epd_gdoe;
    logic                                epd_gdclk;
    logic                                epd_gdsp;
    logic                                epd_sdclk;
    logic                                epd_sdle;
    logic                                epd_sdoe;
    logic                                epd_sdce0;
    logic [N-1:0][wvfm_pkg::DRIVE_W-1:0] epd_sd;

    integer                       seed = 45385;
    int                           cycle_cnt = 0;
    int                           mode = MODE_STEADY;
    int                           cur_test = 1;
    int                           items_sent = 0;
    int                           results_seen = 0;
    int                           trig_cnt = 0;
    int                           ready_cnt = 0;
    int                           sdce_cnt = 0;
    int                           err_cnt [1:5] = '{default: 0};
    logic                         killed = 1'b0;
    logic                         ready_seen = 1'b0;
    result_t                      exp_q [$];
    wvfm_pkg::pix_state_t [N-1:0] fb_state [ITEMS];

    `include "tb_ref_model.svh"

    epd_caster #(
        .H_FP       (H_FP),
        .H_SYNC     (H_SYNC),
        .H_BP       (H_BP),
        .H_ACT      (H_ACT),
        .V_FP       (V_FP),
        .V_SYNC     (V_SYNC),
        .V_BP       (V_BP),
        .V_ACT      (V_ACT),
        .LUT_FRAMES (LUT_FRAMES)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .vin_vsync (vin_vsync),
        .vin_pixel (vin_pixel),
        .vin_valid (vin_valid),
        .vin_ready (vin_ready),
        .bi_pixel  (bi_pixel),
        .bi_valid  (bi_valid),
        .bi_ready  (bi_ready),
        .bo_pixel  (bo_pixel),
        .bo_valid  (bo_valid),
        .lut_wr    (lut_wr),
        .sys_ready (sys_ready),
        .global_en (global_en),
        .b_trigger (b_trigger),
        .epd_gdoe  (epd_gdoe),
        .epd_gdclk (epd_gdclk),
        .epd_gdsp  (epd_gdsp),
        .epd_sdclk (epd_sdclk),
        .epd_sdle  (epd_sdle),
        .epd_sdoe  (epd_sdoe),
        .epd_sdce0 (epd_sdce0),
        .epd_sd    (epd_sd)
    );

    always #10 clk = ~clk;

    // Stimulus words for one clock of four pixels
    task automatic make_item(
        input  int                           idx,
        output logic [N-1:0][7:0]            vin,
        output wvfm_pkg::pix_state_t [N-1:0] bi
    );
        logic [31:0] r;
        for (int i = 0; i < N; i++) begin
            r = $random(seed);
            vin[i] = r[7:0];
            bi[i] = r[31:16];
            case (mode)
                MODE_STEADY: begin
                    bi[i].fcnt = '0;
                    vin[i][7:4] = bi[i].src;
                end
                MODE_FEEDBACK: bi[i] = fb_state[idx][i];
                default: bi[i].fcnt = FW'(r[15:8] % LUT_FRAMES);
            endcase
        end
    endtask

    // FIFO model that answers the ready seen before this edge
    always @(posedge clk) begin : fifo_model
        logic [N-1:0][7:0]            vin_d;
        wvfm_pkg::pix_state_t [N-1:0] bi_d;
        logic                         starve;
        logic                         kill;
        result_t                      exp_item;
        #2;
        if (ready_seen) begin
            make_item(items_sent, vin_d, bi_d);
            starve = (mode == MODE_STARVE) && (items_sent == STARVE_IDX);
            kill = killed || starve;
            if (starve) begin
                killed = 1'b1;
            end
            ref_beat(vin_d, bi_d, FW'(LUT_FRAMES), kill, exp_item.sd, exp_item.bo);
            fb_state[items_sent] = exp_item.bo;
            exp_q.push_back(exp_item);
            vin_pixel = vin_d;
            bi_pixel = bi_d;
            vin_valid = !starve;
            bi_valid = !starve;
            items_sent++;
        end else begin
            vin_valid = 1'b0;
            bi_valid = 1'b0;
        end
    end

    // Compare and timing monitor at the falling edge
    always @(negedge clk) begin : compare
        result_t want;
        ready_seen = vin_ready;
        if (!rst) begin
            if (b_trigger) begin
                trig_cnt++;
            end
            if (vin_ready) begin
                ready_cnt++;
            end
            if (!epd_sdce0) begin
                sdce_cnt++;
            end
            if (vin_ready !== bi_ready) begin
                $display("FAILED bi_ready: got %h expected %h", bi_ready, vin_ready);
                err_cnt[2]++;
            end
            if (bo_valid) begin
                if (exp_q.size() == 0) begin
                    $display("bo_valid is high but no item was sent for it");
                    err_cnt[cur_test]++;
                end else begin
                    want = exp_q.pop_front();
                    if (bo_pixel !== want.bo) begin
                        $display("FAILED bo_pixel item %0d: got %h expected %h",
                                 results_seen, bo_pixel, want.bo);
                        err_cnt[cur_test]++;
                    end
                    if (epd_sd !== want.sd) begin
                        $display("FAILED epd_sd item %0d: got %h expected %h",
                                 results_seen, epd_sd, want.sd);
                        err_cnt[cur_test]++;
                    end
                end
                results_seen++;
            end else if (epd_sd !== '0) begin
                $display("FAILED epd_sd idle: got %h expected %h", epd_sd, 8'h00);
                err_cnt[cur_test]++;
            end
        end
    end

    // Source clock is the inverted clock during active pixels
    always @(negedge clk) begin : sdclk_check
        #1;
        if (!rst && !epd_sdce0 && epd_sdclk !== 1'b1) begin
            $display("FAILED epd_sdclk: got %h expected %h", epd_sdclk, 1'b1);
            err_cnt[2]++;
        end
    end

    initial begin : watchdog
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, the frames did not complete", cycle_cnt);
        $display("Test FAILED");
        $finish;
    end

    task automatic load_lut();
        logic [31:0] r;
        for (int a = 0; a < LOAD_N; a++) begin
            @(posedge clk);
            #2;
            r = $random(seed);
            lut_wr.we = 1'b1;
            lut_wr.addr = a[wvfm_pkg::LUT_ADDR_W-1:0];
            lut_wr.data = r[1:0];
            lut_shadow[a] = r[1:0];
        end
        @(posedge clk);
        #2;
        lut_wr.we = 1'b0;
    endtask

    // One vsync and a wait until all results are in and the scan is idle
    task automatic run_frame(input int m, input int t);
        mode = m;
        cur_test = t;
        @(posedge clk);
        #2;
        items_sent = 0;
        killed = 1'b0;
        trig_cnt = 0;
        ready_cnt = 0;
        sdce_cnt = 0;
        vin_vsync = 1'b1;
        @(posedge clk);
        #2;
        vin_vsync = 1'b0;
        @(negedge clk);
        while (items_sent < ITEMS || exp_q.size() != 0 || epd_gdoe) begin
            @(negedge clk);
        end
        if (trig_cnt != epd_timing_pkg::VS_DELAY + 1) begin
            $display("FAILED b_trigger cycles: got %h expected %h",
                     trig_cnt, epd_timing_pkg::VS_DELAY + 1);
            err_cnt[2]++;
        end
        if (ready_cnt != ITEMS) begin
            $display("FAILED vin_ready cycles: got %h expected %h", ready_cnt, ITEMS);
            err_cnt[2]++;
        end
        if (sdce_cnt != ITEMS) begin
            $display("FAILED epd_sdce0 cycles: got %h expected %h", sdce_cnt, ITEMS);
            err_cnt[2]++;
        end
    endtask

    task automatic report_test(input int t, input string name);
        $display("[%0d] %s: %s, %0d errors", t, name,
                 (err_cnt[t] == 0) ? "pass" : "fail", err_cnt[t]);
    endtask

    initial begin : main
        int failed;
        int total;
        rst = 1'b1;
        vin_vsync = 1'b0;
        vin_pixel = '0;
        vin_valid = 1'b0;
        bi_pixel = '0;
        bi_valid = 1'b0;
        lut_wr = '0;
        sys_ready = 1'b0;
        global_en = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        if ({b_trigger, vin_ready, bi_ready, bo_valid, epd_gdoe, epd_sdoe, epd_sdle,
             epd_gdclk, epd_sdclk} !== 9'h000) begin
            $display("FAILED reset outputs: got %h expected %h",
                     {b_trigger, vin_ready, bi_ready, bo_valid, epd_gdoe, epd_sdoe,
                      epd_sdle, epd_gdclk, epd_sdclk}, 9'h000);
            err_cnt[1]++;
        end
        if (epd_sd !== '0) begin
            $display("FAILED epd_sd after reset: got %h expected %h", epd_sd, 8'h00);
            err_cnt[1]++;
        end
        if (epd_gdsp !== 1'b1) begin
            $display("FAILED epd_gdsp after reset: got %h expected %h", epd_gdsp, 1'b1);
            err_cnt[1]++;
        end
        report_test(1, "outputs after reset");

        load_lut();
        sys_ready = 1'b1;
        global_en = 1'b1;

        run_frame(MODE_STEADY, 3);
        report_test(3, "steady pixels");
        run_frame(MODE_RANDOM, 4);
        run_frame(MODE_FEEDBACK, 4);
        run_frame(MODE_FEEDBACK, 4);
        report_test(4, "random transitions with writeback");
        run_frame(MODE_STARVE, 5);
        run_frame(MODE_RANDOM, 5);
        report_test(5, "frame kill on underrun");
        report_test(2, "trigger length and window cycles");

        failed = 0;
        total = 0;
        for (int t = 1; t <= 5; t++) begin
            total += err_cnt[t];
            if (err_cnt[t] != 0) begin
                failed++;
            end
        end
        $display("Summary: 5 tests, %0d passed, %0d failed, %0d errors",
                 5 - failed, failed, total);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
verilog/epd_timing_pkg.sv
verilog/wvfm_pkg.sv
verilog/scan_fsm.sv
verilog/scan_timing.sv
verilog/wvfm_lut.sv
verilog/pixel_pipeline.sv
verilog/epd_caster.sv
sim/tb_epd_caster.sv

// File: Bender.yml
package:
  name: epd_caster

sources:
  - files:
      - verilog/epd_timing_pkg.sv
      - verilog/wvfm_pkg.sv
      - verilog/scan_fsm.sv
      - verilog/scan_timing.sv
      - verilog/wvfm_lut.sv
      - verilog/pixel_pipeline.sv
      - verilog/epd_caster.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_epd_caster.sv
